// ==== verilog/fetch_const_pkg.sv ====
package fetch_const_pkg;

  // data and address width of the core
  localparam int xlen = 32;

  // first fetch address after reset
  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  // trap vector until software writes mtvec
  localparam logic [xlen-1:0] mtvec_reset = 32'h0000_0100;

  // major opcodes seen by the predecoder
  localparam logic [6:0] opcode_jal = 7'h6F;
  localparam logic [6:0] opcode_branch = 7'h63;

  // machine mode csr numbers held by the trap block
  localparam logic [11:0] csr_mtvec = 12'h305;
  localparam logic [11:0] csr_mepc = 12'h341;

endpackage

// ==== verilog/fetch_types_pkg.sv ====
package fetch_types_pkg;

  typedef logic [fetch_const_pkg::xlen-1:0] addr_t;

  // conditional branch, B-type layout
  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  // jump and link, J-type layout
  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // one fetched word, read both as a branch and as a jal
  typedef union packed {
    logic [31:0] raw;
    b_fmt_t      b;
    j_fmt_t      j;
  } instr_u;

endpackage

// ==== verilog/trap_csr.sv ====
`timescale 1ns/10ps

module trap_csr (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   csr_write,
  input  logic [11:0]            csr_addr,
  input  fetch_types_pkg::addr_t csr_wdata,
  input  logic                   trap,
  input  fetch_types_pkg::addr_t trap_pc,
  input  logic                   mret,
  output logic                   redirect_valid,
  output fetch_types_pkg::addr_t redirect_pc,
  output fetch_types_pkg::addr_t mtvec,
  output fetch_types_pkg::addr_t mepc
);
  import fetch_const_pkg::*;

  logic mtvec_sel;
  logic mepc_sel;

  // csr number decode for the write port
  assign mtvec_sel = csr_write && (csr_addr == csr_mtvec);
  assign mepc_sel = csr_write && (csr_addr == csr_mepc);

  always_ff @(posedge clock) begin
    if (!reset) begin
      mtvec <= mtvec_reset;
    end else if (mtvec_sel) begin
      mtvec <= csr_wdata;
    end
  end

  // the trapping pc is saved even when software writes mepc in the same cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      mepc <= reset_pc;
    end else if (trap) begin
      mepc <= trap_pc;
    end else if (mepc_sel) begin
      mepc <= csr_wdata;
    end
  end

  // trap goes to the vector, mret returns to the saved pc
  assign redirect_valid = trap | mret;
  assign redirect_pc = trap ? mtvec : mepc;

endmodule

// ==== verilog/branch_predecode.sv ====
`timescale 1ns/10ps

module branch_predecode (
  input  logic                    clock,
  input  logic                    reset,
  input  fetch_types_pkg::addr_t  fetch_pc,
  input  fetch_types_pkg::instr_u instr,
  input  logic                    clear,
  input  logic                    redirected,
  output logic                    pred_taken,
  output fetch_types_pkg::addr_t  pred_target
);
  import fetch_const_pkg::*;
  import fetch_types_pkg::*;

  logic  after_redirect;
  logic  is_jal;
  logic  is_branch;
  logic  backward;
  addr_t j_imm;
  addr_t b_imm;

  // high in the first cycle at a redirect target
  always_ff @(posedge clock) begin
    if (!reset) begin
      after_redirect <= 1'b0;
    end else begin
      after_redirect <= redirected;
    end
  end

  assign is_jal = (instr.j.opcode == opcode_jal);
  assign is_branch = (instr.b.opcode == opcode_branch);

  // offset sign bit sits at bit 31 in both formats
  assign backward = instr.b.imm12;

  // J immediate, 21 bits with an implied zero
  assign j_imm = {
    {(xlen-20){instr.j.imm20}},
    instr.j.imm19_12,
    instr.j.imm11,
    instr.j.imm10_1,
    1'b0
  };

  // B immediate, 13 bits with an implied zero
  assign b_imm = {
    {(xlen-12){instr.b.imm12}},
    instr.b.imm11,
    instr.b.imm10_5,
    instr.b.imm4_1,
    1'b0
  };

  // static rule: jal always, conditional branches only when backward
  assign pred_taken = !after_redirect && !clear && (is_jal || (is_branch && backward));

  assign pred_target = fetch_pc + (is_jal ? j_imm : b_imm);

endmodule

// ==== verilog/fetch_stage.sv ====
`timescale 1ns/10ps

module fetch_stage (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   stall,
  input  logic                   clear,
  input  logic                   redirect_valid,
  input  fetch_types_pkg::addr_t redirect_pc,
  input  logic                   pred_taken,
  input  fetch_types_pkg::addr_t pred_target,
  input  logic                   exec_jump,
  input  fetch_types_pkg::addr_t exec_target,
  input  logic                   fence,
  input  fetch_types_pkg::addr_t fence_npc,
  output logic                   imem_valid,
  output fetch_types_pkg::addr_t imem_addr,
  output logic                   imem_fence,
  output logic                   imem_spec,
  output fetch_types_pkg::addr_t fetch_pc,
  output logic                   redirected
);
  import fetch_const_pkg::*;
  import fetch_types_pkg::*;

  logic  running;
  addr_t next_pc;
  logic  next_fence;
  logic  next_spec;

  // next pc select, highest priority first
  always_comb begin
    next_pc = fetch_pc;
    next_fence = 1'b0;
    next_spec = 1'b0;
    if (!running) begin
      // keep requesting the reset address until reset is released
      next_pc = fetch_pc;
    end else if (redirect_valid) begin
      next_pc = redirect_pc;
      next_spec = 1'b1;
    end else if (pred_taken) begin
      next_pc = pred_target;
      next_spec = 1'b1;
    end else if (exec_jump) begin
      next_pc = exec_target;
      next_spec = 1'b1;
    end else if (fence) begin
      next_pc = fence_npc;
      next_fence = 1'b1;
      next_spec = 1'b1;
    end else if (!stall) begin
      next_pc = fetch_pc + xlen'(4);
    end
  end

  // pc of the word that memory returns in this cycle
  always_ff @(posedge clock) begin
    if (!reset) begin
      running <= 1'b0;
      fetch_pc <= reset_pc;
    end else begin
      running <= 1'b1;
      fetch_pc <= next_pc;
    end
  end

  assign imem_valid = ~clear;
  assign imem_addr = next_pc;
  assign imem_fence = next_fence;
  assign imem_spec = next_spec;

  // every non-sequential choice is speculative
  assign redirected = next_spec;

endmodule

// ==== verilog/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    stall,
  input  logic                    clear,
  input  logic                    exec_jump,
  input  fetch_types_pkg::addr_t  exec_target,
  input  logic                    fence,
  input  fetch_types_pkg::addr_t  fence_npc,
  input  logic                    trap,
  input  fetch_types_pkg::addr_t  trap_pc,
  input  logic                    mret,
  input  logic                    csr_write,
  input  logic [11:0]             csr_addr,
  input  fetch_types_pkg::addr_t  csr_wdata,
  input  fetch_types_pkg::instr_u imem_rdata,
  output logic                    imem_valid,
  output fetch_types_pkg::addr_t  imem_addr,
  output logic                    imem_fence,
  output logic                    imem_spec,
  output fetch_types_pkg::addr_t  fetch_pc,
  output fetch_types_pkg::addr_t  mtvec,
  output fetch_types_pkg::addr_t  mepc
);
  import fetch_types_pkg::*;

  logic  redirect_valid;
  addr_t redirect_pc;
  logic  pred_taken;
  addr_t pred_target;
  logic  redirected;

  trap_csr trap_csr_i (
    .clock          (clock),
    .reset          (reset),
    .csr_write      (csr_write),
    .csr_addr       (csr_addr),
    .csr_wdata      (csr_wdata),
    .trap           (trap),
    .trap_pc        (trap_pc),
    .mret           (mret),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .mtvec          (mtvec),
    .mepc           (mepc)
  );

  // predicts on the word returned for the registered pc
  branch_predecode branch_predecode_i (
    .clock       (clock),
    .reset       (reset),
    .fetch_pc    (fetch_pc),
    .instr       (imem_rdata),
    .clear       (clear),
    .redirected  (redirected),
    .pred_taken  (pred_taken),
    .pred_target (pred_target)
  );

  fetch_stage fetch_stage_i (
    .clock          (clock),
    .reset          (reset),
    .stall          (stall),
    .clear          (clear),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .exec_jump      (exec_jump),
    .exec_target    (exec_target),
    .fence          (fence),
    .fence_npc      (fence_npc),
    .imem_valid     (imem_valid),
    .imem_addr      (imem_addr),
    .imem_fence     (imem_fence),
    .imem_spec      (imem_spec),
    .fetch_pc       (fetch_pc),
    .redirected     (redirected)
  );

endmodule

// ==== dv/fetch_tb.sv ====
`timescale 1ns/10ps

module fetch_tb;
  import fetch_const_pkg::*;
  import fetch_types_pkg::*;

  localparam int reset_cycles = 16;
  localparam int directed_cycles = 80;
  localparam int random_cycles = 300;
  localparam int total_cycles = reset_cycles + directed_cycles + random_cycles;

  // word on the bus when no request was made
  localparam logic [31:0] idle_word = 32'h0000_0013;

  logic        clock;
  logic        reset;
  logic        stall;
  logic        clear;
  logic        exec_jump;
  addr_t       exec_target;
  logic        fence;
  addr_t       fence_npc;
  logic        trap;
  addr_t       trap_pc;
  logic        mret;
  logic        csr_write;
  logic [11:0] csr_addr;
  addr_t       csr_wdata;
  instr_u      imem_rdata;
  logic        imem_valid;
  addr_t       imem_addr;
  logic        imem_fence;
  logic        imem_spec;
  addr_t       fetch_pc;
  addr_t       mtvec;
  addr_t       mepc;

  logic [31:0] imem [256];

  // model copies of the front end state
  logic        ref_running;
  addr_t       ref_pc;
  logic        ref_mark;
  addr_t       ref_mtvec;
  addr_t       ref_mepc;
  logic [31:0] ref_word;

  fetch_top fetch_top_i (
    .clock       (clock),
    .reset       (reset),
    .stall       (stall),
    .clear       (clear),
    .exec_jump   (exec_jump),
    .exec_target (exec_target),
    .fence       (fence),
    .fence_npc   (fence_npc),
    .trap        (trap),
    .trap_pc     (trap_pc),
    .mret        (mret),
    .csr_write   (csr_write),
    .csr_addr    (csr_addr),
    .csr_wdata   (csr_wdata),
    .imem_rdata  (imem_rdata),
    .imem_valid  (imem_valid),
    .imem_addr   (imem_addr),
    .imem_fence  (imem_fence),
    .imem_spec   (imem_spec),
    .fetch_pc    (fetch_pc),
    .mtvec       (mtvec),
    .mepc        (mepc)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  function automatic logic [31:0] mem_word(input addr_t addr);
    return imem[addr[9:2]];
  endfunction

  // memory answers one cycle after the request
  initial begin
    imem_rdata = idle_word;
    forever begin
      @(posedge clock);
      imem_rdata <= imem_valid ? mem_word(imem_addr) : idle_word;
    end
  end

  function automatic logic [31:0] make_add();
    return {7'h00, 5'd3, 5'd2, 3'b000, 5'd1, 7'h33};
  endfunction

  function automatic logic [31:0] make_jal(input logic [31:0] off);
    instr_u w;
    w.raw = 32'h0;
    w.j.opcode = opcode_jal;
    w.j.rd = 5'd1;
    w.j.imm20 = off[20];
    w.j.imm19_12 = off[19:12];
    w.j.imm11 = off[11];
    w.j.imm10_1 = off[10:1];
    return w.raw;
  endfunction

  function automatic logic [31:0] make_branch(input logic [31:0] off);
    instr_u w;
    w.raw = 32'h0;
    w.b.opcode = opcode_branch;
    w.b.rs1 = 5'd2;
    w.b.rs2 = 5'd3;
    w.b.imm12 = off[12];
    w.b.imm11 = off[11];
    w.b.imm10_5 = off[10:5];
    w.b.imm4_1 = off[4:1];
    return w.raw;
  endfunction

  task automatic load_memory();
    for (int i = 0; i < 256; i++) begin
      if (i < 64 || i % 6 > 2) begin
        imem[i] = make_add();
      end else if (i % 6 == 0) begin
        imem[i] = make_jal((i % 16 < 8) ? 32'd24 : -32'd48);
      end else if (i % 6 == 1) begin
        imem[i] = make_branch(-32'd12);
      end else begin
        imem[i] = make_branch(32'd20);
      end
    end
    // small loop at 0x200 with a jal, a forward and a backward branch
    imem[128] = make_add();
    imem[129] = make_jal(32'd12);
    imem[130] = make_branch(32'd16);
    imem[131] = make_add();
    imem[132] = make_add();
    imem[133] = make_branch(-32'd16);
  endtask

  // next pc and flags from the fetch rules
  function automatic void expected_fetch(output addr_t npc, output logic nfence,
                                         output logic nspec);
    logic  is_jal;
    logic  is_back;
    logic  take;
    addr_t off;
    is_jal = (ref_word[6:0] == opcode_jal);
    is_back = (ref_word[6:0] == opcode_branch) && ref_word[31];
    take = !ref_mark && !clear && (is_jal || is_back);
    if (is_jal) begin
      off = {{12{ref_word[31]}}, ref_word[19:12], ref_word[20], ref_word[30:21], 1'b0};
    end else begin
      off = {{20{ref_word[31]}}, ref_word[7], ref_word[30:25], ref_word[11:8], 1'b0};
    end
    npc = ref_pc;
    nfence = 1'b0;
    nspec = 1'b0;
    if (!ref_running) begin
      npc = ref_pc;
    end else if (trap || mret) begin
      npc = trap ? ref_mtvec : ref_mepc;
      nspec = 1'b1;
    end else if (take) begin
      npc = ref_pc + off;
      nspec = 1'b1;
    end else if (exec_jump) begin
      npc = exec_target;
      nspec = 1'b1;
    end else if (fence) begin
      npc = fence_npc;
      nfence = 1'b1;
      nspec = 1'b1;
    end else if (!stall) begin
      npc = ref_pc + 32'd4;
    end
  endfunction

  task automatic fail_run();
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_addr(input string name, input addr_t got, input addr_t exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      fail_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s is %h, expected %h at %0t", name, got, exp, $time);
      fail_run();
    end
  endtask

  initial begin : compare_outputs
    addr_t exp_pc;
    logic  exp_fence;
    logic  exp_spec;
    ref_running = 1'b0;
    ref_pc = reset_pc;
    ref_mark = 1'b0;
    ref_mtvec = mtvec_reset;
    ref_mepc = reset_pc;
    ref_word = idle_word;
    wait (reset === 1'b1);
    forever begin
      @(negedge clock);
      expected_fetch(exp_pc, exp_fence, exp_spec);
      check_flag("imem_valid", imem_valid, !clear);
      check_addr("fetch_pc", fetch_pc, ref_pc);
      check_addr("imem_addr", imem_addr, exp_pc);
      check_flag("imem_fence", imem_fence, exp_fence);
      check_flag("imem_spec", imem_spec, exp_spec);
      check_addr("mtvec", mtvec, ref_mtvec);
      check_addr("mepc", mepc, ref_mepc);
      // state after the coming edge
      if (csr_write && csr_addr == csr_mtvec) begin
        ref_mtvec = csr_wdata;
      end
      if (trap) begin
        ref_mepc = trap_pc;
      end else if (csr_write && csr_addr == csr_mepc) begin
        ref_mepc = csr_wdata;
      end
      ref_word = clear ? idle_word : mem_word(exp_pc);
      ref_mark = exp_spec;
      ref_running = 1'b1;
      ref_pc = exp_pc;
    end
  end

  initial begin
    #(total_cycles * 4 + 400);
    $display("watchdog expired before the tests completed");
    fail_run();
  end

  task automatic drop_pulses();
    exec_jump <= 1'b0;
    fence <= 1'b0;
    trap <= 1'b0;
    mret <= 1'b0;
    csr_write <= 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clock);
      drop_pulses();
    end
  endtask

  function automatic addr_t random_target();
    return $urandom & 32'h0000_03FC;
  endfunction

  task automatic drive_random();
    logic [31:0] r;
    r = $urandom;
    stall <= (r[1:0] == 2'd0);
    clear <= (r[4:2] == 3'd0);
    trap <= (r[7:5] == 3'd0);
    mret <= (r[10:8] == 3'd0);
    exec_jump <= (r[13:11] == 3'd0);
    fence <= (r[16:14] == 3'd0);
    csr_write <= (r[19:17] == 3'd0);
    csr_addr <= r[20] ? csr_mtvec : (r[21] ? csr_mepc : 12'h300);
    exec_target <= random_target();
    fence_npc <= random_target();
    trap_pc <= random_target();
    csr_wdata <= random_target();
  endtask

  initial begin
    void'($urandom(81));
    load_memory();
    reset = 1'b0;
    stall = 1'b0;
    clear = 1'b0;
    exec_jump = 1'b0;
    exec_target = '0;
    fence = 1'b0;
    fence_npc = '0;
    trap = 1'b0;
    trap_pc = '0;
    mret = 1'b0;
    csr_write = 1'b0;
    csr_addr = '0;
    csr_wdata = '0;
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b1;
    // sequential fetch from the reset address
    idle(12);
    @(posedge clock);
    stall <= 1'b1;
    idle(5);
    @(posedge clock);
    stall <= 1'b0;
    clear <= 1'b1;
    idle(3);
    @(posedge clock);
    clear <= 1'b0;
    idle(4);
    // into the jal and branch loop
    @(posedge clock);
    exec_jump <= 1'b1;
    exec_target <= 32'h0000_0200;
    idle(24);
    @(posedge clock);
    csr_write <= 1'b1;
    csr_addr <= csr_mtvec;
    csr_wdata <= 32'h0000_0300;
    @(posedge clock);
    csr_write <= 1'b0;
    trap <= 1'b1;
    trap_pc <= 32'h0000_00A0;
    idle(6);
    @(posedge clock);
    mret <= 1'b1;
    idle(8);
    repeat (random_cycles) begin
      @(posedge clock);
      drive_random();
    end
    @(posedge clock);
    stall <= 1'b0;
    clear <= 1'b0;
    drop_pulses();
    idle(4);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

// ==== all.f ====
verilog/fetch_const_pkg.sv
verilog/fetch_types_pkg.sv
verilog/trap_csr.sv
verilog/branch_predecode.sv
verilog/fetch_stage.sv
verilog/fetch_top.sv
dv/fetch_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# compile and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -f all.f --top-module fetch_tb -o fetch_sim

# the simulator exits non-zero on a failure, so keep going and judge by the log
./obj_dir/fetch_sim | tee sim.log

if grep -q "Simulation finished: PASS" sim.log; then
  echo "run_sim: testbench passed"
  exit 0
else
  echo "run_sim: testbench did not pass"
  exit 1
fi
